//--- include/mam_config.svh
/*
 * Memory access engine configuration
 * Word and address sizes, packet length limit, FIFO depths, event flags
 */

`ifndef MAM_CONFIG_SVH
`define MAM_CONFIG_SVH

// Memory port geometry
`define MAM_DATA_WIDTH      32
`define MAM_ADDR_WIDTH      32
`define MAM_FLITS_PER_WORD  2     // 16-bit flits per word
`define MAM_ADDR_FLITS      2     // 16-bit flits per address

// Debug packet framing
`define MAM_MAX_PKT_LEN     8     // Header flits included
`define MAM_EVENT_FLAGS     16'h8000

// Buffering
`define MAM_IN_DEPTH        4
`define MAM_RD_DEPTH        2

`endif

//--- logic/mam_pkg.sv
/*
 * Memory access engine types
 * Debug flit and memory port payloads
 */

`include "mam_config.svh"

package mam_pkg;

  // One debug network flit
  typedef struct packed {
    logic [15:0] data;
    logic        last;   // Final flit of a packet
  } flit_t;

  // Memory port payloads
  typedef logic [`MAM_DATA_WIDTH-1:0]   word_t;
  typedef logic [`MAM_ADDR_WIDTH-1:0]   addr_t;
  typedef logic [`MAM_DATA_WIDTH/8-1:0] strb_t;

  // Burst length in words
  typedef logic [12:0] beats_t;

endpackage

//--- logic/mam_fifo.sv
/*
 * Synchronous FIFO with valid/ready on both sides
 * Payload type and depth set by parameters
 */

`timescale 1ns/1ns

module mam_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 2
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam logic [PW-1:0] LAST_SLOT = PW'(DEPTH - 1);
  localparam logic [PW:0]   FULL      = (PW + 1)'(DEPTH);

  payload_t      mem [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [PW:0]   count;
  logic          push;
  logic          pop;

  assign in_ready  = (count != FULL);
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];   // Head entry
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
      if (pop) rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;     // Idle or push and pop together
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= in_data;
  end

endmodule

//--- logic/mam_cmd_parser.sv
/*
 * Command parser of the memory access engine
 * Decodes command packets into a request and assembles write words
 */

`timescale 1ns/1ns
`include "mam_config.svh"

module mam_cmd_parser (
  input  logic            clk,
  input  logic            rst,
  input  logic            flit_valid,
  output logic            flit_ready,
  input  mam_pkg::flit_t  flit_data,
  output logic            cmd_valid,
  input  logic            cmd_ready,
  output logic            cmd_we,
  output logic            cmd_burst,
  output mam_pkg::addr_t  cmd_addr,
  output mam_pkg::beats_t cmd_beats,
  output mam_pkg::strb_t  cmd_strb,
  output logic [15:0]     cmd_src,
  output logic            wword_valid,
  input  logic            wword_ready,
  output mam_pkg::word_t  wword_data
);
  import mam_pkg::*;

  localparam int FPW = `MAM_FLITS_PER_WORD;
  localparam int AF  = `MAM_ADDR_FLITS;
  localparam int WCW = (FPW > 1) ? $clog2(FPW) : 1;
  localparam int ACW = (AF > 1) ? $clog2(AF) : 1;
  localparam logic [WCW-1:0] W_LAST = WCW'(FPW - 1);
  localparam logic [ACW-1:0] A_LAST = ACW'(AF - 1);

  typedef enum logic [2:0] {
    ST_DEST, ST_SRC, ST_FLAGS, ST_HDR, ST_ADDR, ST_CMD, ST_DATA
  } state_t;

  state_t         state;
  logic [ACW-1:0] fcnt;       // Address flit index
  logic [WCW-1:0] wcnt;       // Flit index within a write word
  logic           flit_fire;
  logic           word_fire;
  logic           word_done;

  ////////////////////////////////
  // Handshakes
  ////////////////////////////////

  assign cmd_valid  = (state == ST_CMD);
  assign flit_ready = (state != ST_CMD) &&
                      ((state != ST_DATA) || !wword_valid || wword_ready);
  assign flit_fire  = flit_valid && flit_ready;
  assign word_fire  = wword_valid && wword_ready;
  assign word_done  = (state == ST_DATA) && flit_fire && (wcnt == W_LAST);

  ////////////////////////////////
  // Packet FSM
  ////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= ST_DEST;
      fcnt        <= '0;
      wcnt        <= '0;
      wword_valid <= 1'b0;
    end else begin
      if (word_done) wword_valid <= 1'b1;
      else if (word_fire) wword_valid <= 1'b0;

      case (state)
        ST_DEST:  if (flit_fire) state <= ST_SRC;    // Not checked
        ST_SRC:   if (flit_fire) state <= ST_FLAGS;
        ST_FLAGS: if (flit_fire) state <= ST_HDR;    // Ignored
        ST_HDR: begin
          if (flit_fire) begin
            state <= ST_ADDR;
            fcnt  <= '0;
            wcnt  <= '0;
          end
        end
        ST_ADDR: begin
          if (flit_fire) begin
            fcnt <= fcnt + 1'b1;
            if (fcnt == A_LAST) state <= ST_CMD;
          end
        end
        ST_CMD: begin
          // Reads end with the address, writes carry their data
          if (cmd_ready) state <= cmd_we ? ST_DATA : ST_DEST;
        end
        ST_DATA: begin
          if (flit_fire) begin
            wcnt <= word_done ? '0 : wcnt + 1'b1;
            if (flit_data.last) state <= ST_DEST;
          end
        end
        default: state <= ST_DEST;
      endcase
    end
  end

  ////////////////////////////////
  // Command and write word fields
  ////////////////////////////////

  always_ff @(posedge clk) begin
    if (flit_fire) begin
      case (state)
        ST_SRC: cmd_src <= flit_data.data;
        ST_HDR: begin
          cmd_we    <= flit_data.data[15];
          cmd_burst <= flit_data.data[14];
          cmd_beats <= flit_data.data[14] ? beats_t'(flit_data.data[7:0]) : beats_t'(1);
          cmd_strb  <= flit_data.data[14] ? '1 : flit_data.data[$bits(strb_t)-1:0];
        end
        ST_ADDR: cmd_addr[(AF - 1 - int'(fcnt)) * 16 +: 16] <= flit_data.data;   // High half first
        ST_DATA: wword_data[(FPW - 1 - int'(wcnt)) * 16 +: 16] <= flit_data.data;
        default: ;
      endcase
    end
  end

endmodule

//--- logic/mam_mem_sequencer.sv
/*
 * Memory sequencer of the memory access engine
 * Issues requests, streams write beats, hands reads to the response side
 */

`timescale 1ns/1ns

module mam_mem_sequencer (
  input  logic            clk,
  input  logic            rst,
  input  logic            cmd_valid,
  output logic            cmd_ready,
  input  logic            cmd_we,
  input  logic            cmd_burst,
  input  mam_pkg::addr_t  cmd_addr,
  input  mam_pkg::beats_t cmd_beats,
  input  mam_pkg::strb_t  cmd_strb,
  input  logic [15:0]     cmd_src,
  input  logic            wword_valid,
  output logic            wword_ready,
  input  mam_pkg::word_t  wword_data,
  output logic            req_valid,
  input  logic            req_ready,
  output logic            req_we,
  output mam_pkg::addr_t  req_addr,
  output logic            req_burst,
  output mam_pkg::beats_t req_beats,
  output logic            write_valid,
  input  logic            write_ready,
  output mam_pkg::word_t  write_data,
  output mam_pkg::strb_t  write_strb,
  output logic            rsp_valid,
  input  logic            rsp_ready,
  output logic [15:0]     rsp_dest,
  output mam_pkg::beats_t rsp_beats
);
  import mam_pkg::*;

  typedef enum logic [1:0] {SQ_IDLE, SQ_REQ, SQ_WRITE, SQ_RSP} state_t;

  state_t      state;
  logic        we_q;
  logic        burst_q;
  addr_t       addr_q;
  beats_t      beats_q;    // Beats left while writing
  strb_t       strb_q;
  logic [15:0] src_q;
  logic        write_fire;

  assign cmd_ready   = (state == SQ_IDLE);
  assign req_valid   = (state == SQ_REQ);
  assign req_we      = we_q;
  assign req_addr    = addr_q;
  assign req_burst   = burst_q;
  assign req_beats   = beats_q;

  // Write beats flow straight from the parser word register
  assign write_valid = (state == SQ_WRITE) && wword_valid;
  assign wword_ready = (state == SQ_WRITE) && write_ready;
  assign write_data  = wword_data;
  assign write_strb  = strb_q;
  assign write_fire  = write_valid && write_ready;

  assign rsp_valid   = (state == SQ_RSP);
  assign rsp_dest    = src_q;
  assign rsp_beats   = beats_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= SQ_IDLE;
    end else begin
      case (state)
        SQ_IDLE:  if (cmd_valid) state <= SQ_REQ;
        SQ_REQ:   if (req_ready) state <= we_q ? SQ_WRITE : SQ_RSP;
        SQ_WRITE: if (write_fire && (beats_q == beats_t'(1))) state <= SQ_IDLE;
        SQ_RSP:   if (rsp_ready) state <= SQ_IDLE;
        default:  state <= SQ_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_valid && cmd_ready) begin
      we_q    <= cmd_we;
      burst_q <= cmd_burst;
      addr_q  <= cmd_addr;
      beats_q <= cmd_beats;
      strb_q  <= cmd_strb;
      src_q   <= cmd_src;
    end else if (write_fire) begin
      beats_q <= beats_q - 1'b1;
    end
  end

endmodule

//--- logic/mam_resp_builder.sv
/*
 * Response builder of the memory access engine
 * Frames read words into event packets, split at the packet length limit
 */

`timescale 1ns/1ns
`include "mam_config.svh"

module mam_resp_builder (
  input  logic            clk,
  input  logic            rst,
  input  logic            rsp_valid,
  output logic            rsp_ready,
  input  logic [15:0]     rsp_dest,
  input  mam_pkg::beats_t rsp_beats,
  input  logic [15:0]     id,
  input  logic            rd_valid,
  output logic            rd_ready,
  input  mam_pkg::word_t  rd_data,
  output logic            debug_out_valid,
  output logic [15:0]     debug_out_data,
  output logic            debug_out_last,
  input  logic            debug_out_ready
);
  import mam_pkg::*;

  localparam int FPW = `MAM_FLITS_PER_WORD;
  localparam int HCW = (FPW > 1) ? $clog2(FPW) : 1;
  localparam int FCW = $clog2(`MAM_MAX_PKT_LEN);
  localparam logic [HCW-1:0] H_LAST   = HCW'(FPW - 1);
  localparam logic [FCW-1:0] F_LAST   = FCW'(`MAM_MAX_PKT_LEN - 1);
  localparam logic [FCW-1:0] F_ID     = FCW'(1);
  localparam logic [FCW-1:0] F_FLAGS  = FCW'(2);

  typedef enum logic [1:0] {BD_IDLE, BD_HDR, BD_DATA} state_t;

  state_t         state;
  logic [15:0]    dest_q;
  beats_t         beats_q;      // Words still to send
  logic [FCW-1:0] fcnt;         // Flit position in packet
  logic [HCW-1:0] hcnt;         // Half of the current word
  logic           out_fire;
  logic           word_end;
  logic           pkt_end;
  logic           final_beat;

  assign word_end   = (hcnt == H_LAST);
  assign pkt_end    = (fcnt == F_LAST);
  assign final_beat = word_end && (beats_q == beats_t'(1));

  assign rsp_ready       = (state == BD_IDLE);
  assign debug_out_valid = (state == BD_HDR) || ((state == BD_DATA) && rd_valid);
  assign debug_out_last  = (state == BD_DATA) && (pkt_end || final_beat);
  assign rd_ready        = (state == BD_DATA) && word_end && debug_out_ready;  // Pop after low half
  assign out_fire        = debug_out_valid && debug_out_ready;

  always_comb begin
    if (state == BD_DATA) debug_out_data = rd_data[(FPW - 1 - int'(hcnt)) * 16 +: 16];
    else if (fcnt == F_ID) debug_out_data = id;
    else if (fcnt == F_FLAGS) debug_out_data = `MAM_EVENT_FLAGS;
    else debug_out_data = dest_q;   // Back to the command source
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= BD_IDLE;
      beats_q <= '0;
      fcnt    <= '0;
      hcnt    <= '0;
    end else begin
      case (state)
        BD_IDLE: begin
          if (rsp_valid) begin
            state   <= BD_HDR;
            beats_q <= rsp_beats;
            fcnt    <= '0;
            hcnt    <= '0;
          end
        end
        BD_HDR: begin
          if (out_fire) begin
            fcnt <= fcnt + 1'b1;
            if (fcnt == F_FLAGS) state <= BD_DATA;
          end
        end
        BD_DATA: begin
          if (out_fire) begin
            fcnt <= pkt_end ? '0 : fcnt + 1'b1;
            hcnt <= word_end ? '0 : hcnt + 1'b1;   // A word may straddle two packets
            if (word_end) beats_q <= beats_q - 1'b1;
            if (final_beat) state <= BD_IDLE;
            else if (pkt_end) state <= BD_HDR;
          end
        end
        default: state <= BD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rsp_valid && rsp_ready) dest_q <= rsp_dest;
  end

endmodule

//--- logic/mam_top.sv
/*
 * Memory access engine for the debug network
 * Input FIFO, command parser, memory sequencer, read FIFO, response builder
 */

`timescale 1ns/1ns
`include "mam_config.svh"

module mam_top (
  input  logic            clk,
  input  logic            rst,
  input  logic [15:0]     id,
  input  logic [15:0]     debug_in_data,
  input  logic            debug_in_last,
  input  logic            debug_in_valid,
  output logic            debug_in_ready,
  output logic [15:0]     debug_out_data,
  output logic            debug_out_last,
  output logic            debug_out_valid,
  input  logic            debug_out_ready,
  output logic            req_valid,
  input  logic            req_ready,
  output logic            req_we,
  output mam_pkg::addr_t  req_addr,
  output logic            req_burst,
  output mam_pkg::beats_t req_beats,
  output logic            write_valid,
  input  logic            write_ready,
  output mam_pkg::word_t  write_data,
  output mam_pkg::strb_t  write_strb,
  input  logic            read_valid,
  output logic            read_ready,
  input  mam_pkg::word_t  read_data
);
  import mam_pkg::*;

  //////////////////////////////
  // Internal links
  //////////////////////////////

  logic        flit_valid;
  logic        flit_ready;
  flit_t       flit_data;
  logic        cmd_valid;
  logic        cmd_ready;
  logic        cmd_we;
  logic        cmd_burst;
  addr_t       cmd_addr;
  beats_t      cmd_beats;
  strb_t       cmd_strb;
  logic [15:0] cmd_src;
  logic        wword_valid;
  logic        wword_ready;
  word_t       wword_data;
  logic        rsp_valid;
  logic        rsp_ready;
  logic [15:0] rsp_dest;
  beats_t      rsp_beats;
  logic        rd_valid;
  logic        rd_ready;
  word_t       rd_data;

  mam_fifo #(
    .payload_t (flit_t),
    .DEPTH     (`MAM_IN_DEPTH)
  ) i_in_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (debug_in_valid),
    .in_ready  (debug_in_ready),
    .in_data   (flit_t'({debug_in_data, debug_in_last})),
    .out_valid (flit_valid),
    .out_ready (flit_ready),
    .out_data  (flit_data)
  );

  mam_cmd_parser i_cmd_parser (
    .clk         (clk),
    .rst         (rst),
    .flit_valid  (flit_valid),
    .flit_ready  (flit_ready),
    .flit_data   (flit_data),
    .cmd_valid   (cmd_valid),
    .cmd_ready   (cmd_ready),
    .cmd_we      (cmd_we),
    .cmd_burst   (cmd_burst),
    .cmd_addr    (cmd_addr),
    .cmd_beats   (cmd_beats),
    .cmd_strb    (cmd_strb),
    .cmd_src     (cmd_src),
    .wword_valid (wword_valid),
    .wword_ready (wword_ready),
    .wword_data  (wword_data)
  );

  mam_mem_sequencer i_mem_sequencer (
    .clk         (clk),
    .rst         (rst),
    .cmd_valid   (cmd_valid),
    .cmd_ready   (cmd_ready),
    .cmd_we      (cmd_we),
    .cmd_burst   (cmd_burst),
    .cmd_addr    (cmd_addr),
    .cmd_beats   (cmd_beats),
    .cmd_strb    (cmd_strb),
    .cmd_src     (cmd_src),
    .wword_valid (wword_valid),
    .wword_ready (wword_ready),
    .wword_data  (wword_data),
    .req_valid   (req_valid),
    .req_ready   (req_ready),
    .req_we      (req_we),
    .req_addr    (req_addr),
    .req_burst   (req_burst),
    .req_beats   (req_beats),
    .write_valid (write_valid),
    .write_ready (write_ready),
    .write_data  (write_data),
    .write_strb  (write_strb),
    .rsp_valid   (rsp_valid),
    .rsp_ready   (rsp_ready),
    .rsp_dest    (rsp_dest),
    .rsp_beats   (rsp_beats)
  );

  mam_fifo #(
    .payload_t (word_t),
    .DEPTH     (`MAM_RD_DEPTH)
  ) i_rd_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (read_valid),
    .in_ready  (read_ready),
    .in_data   (read_data),
    .out_valid (rd_valid),
    .out_ready (rd_ready),
    .out_data  (rd_data)
  );

  mam_resp_builder i_resp_builder (
    .clk             (clk),
    .rst             (rst),
    .rsp_valid       (rsp_valid),
    .rsp_ready       (rsp_ready),
    .rsp_dest        (rsp_dest),
    .rsp_beats       (rsp_beats),
    .id              (id),
    .rd_valid        (rd_valid),
    .rd_ready        (rd_ready),
    .rd_data         (rd_data),
    .debug_out_valid (debug_out_valid),
    .debug_out_data  (debug_out_data),
    .debug_out_last  (debug_out_last),
    .debug_out_ready (debug_out_ready)
  );

endmodule

//--- verif/mam_sva.sv
/*
 * Handshake checks for the memory access engine
 * Bound to the top level of the engine
 */

`timescale 1ns/1ns

module mam_sva (
  input logic            clk,
  input logic            rst,
  input logic            req_valid,
  input logic            req_ready,
  input logic            req_we,
  input mam_pkg::addr_t  req_addr,
  input logic            req_burst,
  input mam_pkg::beats_t req_beats,
  input logic            write_valid,
  input logic            write_ready,
  input mam_pkg::word_t  write_data,
  input mam_pkg::strb_t  write_strb,
  input logic            debug_out_valid,
  input logic            debug_out_ready,
  input logic [15:0]     debug_out_data,
  input logic            debug_out_last
);

  logic [1:0] pkt_pos;   // Flits seen in the packet, saturates at 3

  always_ff @(posedge clk) begin
    if (rst) begin
      pkt_pos <= '0;
    end else if (debug_out_valid && debug_out_ready) begin
      if (debug_out_last) pkt_pos <= '0;
      else if (pkt_pos != 2'd3) pkt_pos <= pkt_pos + 1'b1;
    end
  end

  ////////////////////////////////
  // Valid held until accepted
  ////////////////////////////////

  a_req_hold: assert property (@(posedge clk) disable iff (rst)
    req_valid && !req_ready |=> req_valid && $stable(req_we) && $stable(req_addr)
      && $stable(req_burst) && $stable(req_beats))
    else $error("request dropped or changed before acceptance");

  a_write_hold: assert property (@(posedge clk) disable iff (rst)
    write_valid && !write_ready |=> write_valid && $stable(write_data) && $stable(write_strb))
    else $error("write beat dropped or changed before acceptance");

  a_out_hold: assert property (@(posedge clk) disable iff (rst)
    debug_out_valid && !debug_out_ready |=> debug_out_valid && $stable(debug_out_data)
      && $stable(debug_out_last))
    else $error("output flit dropped or changed before acceptance");

  a_reset_idle: assert property (@(posedge clk)
    rst && $past(rst) |-> !req_valid && !write_valid && !debug_out_valid)
    else $error("valid output high during reset");

  a_hdr_no_last: assert property (@(posedge clk) disable iff (rst)
    debug_out_valid && (pkt_pos != 2'd3) |-> !debug_out_last)
    else $error("last flag on a header flit");

endmodule

bind mam_top mam_sva i_mam_sva (
  .clk             (clk),
  .rst             (rst),
  .req_valid       (req_valid),
  .req_ready       (req_ready),
  .req_we          (req_we),
  .req_addr        (req_addr),
  .req_burst       (req_burst),
  .req_beats       (req_beats),
  .write_valid     (write_valid),
  .write_ready     (write_ready),
  .write_data      (write_data),
  .write_strb      (write_strb),
  .debug_out_valid (debug_out_valid),
  .debug_out_ready (debug_out_ready),
  .debug_out_data  (debug_out_data),
  .debug_out_last  (debug_out_last)
);

//--- verif/mam_tb.sv
/*
 * Testbench for the memory access engine
 * Golden file stimulus, memory model with random stalls, result checks
 */

`timescale 1ns/1ns

module mam_tb;
  import mam_pkg::*;

  logic        clk;
  logic        rst;
  logic [15:0] id;
  logic [15:0] debug_in_data;
  logic        debug_in_last;
  logic        debug_in_valid;
  logic        debug_in_ready;
  logic [15:0] debug_out_data;
  logic        debug_out_last;
  logic        debug_out_valid;
  logic        debug_out_ready;
  logic        req_valid;
  logic        req_ready;
  logic        req_we;
  addr_t       req_addr;
  logic        req_burst;
  beats_t      req_beats;
  logic        write_valid;
  logic        write_ready;
  word_t       write_data;
  strb_t       write_strb;
  logic        read_valid;
  logic        read_ready;
  word_t       read_data;

  // Golden records
  string       rec_tag[$];
  string       rec_name[$];
  logic [31:0] rec_a[$];
  logic [31:0] rec_b[$];
  logic [31:0] rec_c[$];
  logic [31:0] rec_d[$];

  // Per test stimulus and expectations
  flit_t       cmd_q[$];
  word_t       rd_q[$];
  logic        exp_req_we[$];
  addr_t       exp_req_addr[$];
  logic        exp_req_burst[$];
  beats_t      exp_req_beats[$];
  word_t       exp_wdata[$];
  strb_t       exp_wstrb[$];
  flit_t       exp_flit[$];

  string       cur_name = "reset";
  int          test_errors = 0;
  int          pass_count = 0;
  int          fail_count = 0;
  int          file_errors = 0;   // Bad or unknown golden records
  int          cycles = 0;
  int          limit = 0;
  int          rd_credit = 0;   // Read beats granted but not yet returned
  logic        read_taken = 1'b0;
  logic        stall = 1'b0;
  logic [31:0] lfsr = 32'h66da;

  mam_top i_mam_top (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    rst             = 1'b1;
    id              = '0;
    debug_in_data   = '0;
    debug_in_last   = 1'b0;
    debug_in_valid  = 1'b0;
    debug_out_ready = 1'b0;
    req_ready       = 1'b0;
    write_ready     = 1'b0;
    read_valid      = 1'b0;
    read_data       = '0;
  end

  //////////////////////////////
  // Random bits and checks
  //////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bit(output logic b);
    b    = lfsr[0];
    lfsr = lfsr_next(lfsr);
  endtask

  task automatic check_req(input logic ew, input addr_t ea, input logic eb, input beats_t en,
                           input logic aw, input addr_t aa, input logic ab, input beats_t an);
    if ({ew, ea, eb, en} !== {aw, aa, ab, an}) begin
      $display("FAIL %s request: expected we=%0b addr=%h burst=%0b beats=%0d", cur_name,
               ew, ea, eb, en);
      $display("FAIL %s request: actual   we=%0b addr=%h burst=%0b beats=%0d", cur_name,
               aw, aa, ab, an);
      test_errors++;
    end
  endtask

  task automatic check_word(input word_t ed, input strb_t es, input word_t ad, input strb_t as);
    if ({ed, es} !== {ad, as}) begin
      $display("FAIL %s write: expected %h/%h actual %h/%h", cur_name, ed, es, ad, as);
      test_errors++;
    end
  endtask

  task automatic check_flit(input flit_t e, input flit_t a);
    if (e !== a) begin
      $display("FAIL %s flit: expected %h last=%0b actual %h last=%0b", cur_name,
               e.data, e.last, a.data, a.last);
      test_errors++;
    end
  endtask

  task automatic report_unexpected(input string what);
    $display("Test %s: the DUT produced an unexpected %s", cur_name, what);
    test_errors++;
  endtask

  //////////////////////////////
  // Memory model and monitors
  //////////////////////////////

  always @(posedge clk) begin
    if (!rst) begin
      if (req_valid && req_ready) begin
        if (exp_req_addr.size() == 0) report_unexpected("memory request");
        else check_req(exp_req_we.pop_front(), exp_req_addr.pop_front(),
                       exp_req_burst.pop_front(), exp_req_beats.pop_front(),
                       req_we, req_addr, req_burst, req_beats);
        if (!req_we) rd_credit += int'(req_beats);
      end
      if (write_valid && write_ready) begin
        if (exp_wdata.size() == 0) report_unexpected("write beat");
        else check_word(exp_wdata.pop_front(), exp_wstrb.pop_front(), write_data, write_strb);
      end
      if (debug_out_valid && debug_out_ready) begin
        if (exp_flit.size() == 0) report_unexpected("output flit");
        else check_flit(exp_flit.pop_front(), flit_t'({debug_out_data, debug_out_last}));
      end
      if (read_valid && read_ready) begin
        void'(rd_q.pop_front());
        rd_credit--;
        read_taken = 1'b1;
      end
    end
  end

  always @(negedge clk) begin : drive_memory
    logic b;
    if (stall) begin
      take_bit(b);
      req_ready = b;
      take_bit(b);
      write_ready = b;
      take_bit(b);
      debug_out_ready = b;
    end else begin
      req_ready       = 1'b1;
      write_ready     = 1'b1;
      debug_out_ready = 1'b1;
    end
    // A raised read_valid holds until it transfers
    if (!read_valid || read_taken) begin
      read_taken = 1'b0;
      read_valid = 1'b0;
      if (rd_credit > 0 && rd_q.size() > 0) begin
        b = 1'b1;
        if (stall) take_bit(b);
        read_valid = b;
        read_data  = rd_q[0];
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles >= limit) begin
      $display("Timeout after %0d cycles in test %s, the DUT stopped responding", cycles,
               cur_name);
      $display("Test failed");
      $finish;
    end
  end

  //////////////////////////////
  // Golden file and test flow
  //////////////////////////////

  // Text read with %s, without the zero fill above it
  function automatic string text_of(input logic [255:0] v);
    string s;
    s = "";
    for (int i = 31; i >= 0; i--) begin
      if (v[i*8 +: 8] != 8'h00) s = {s, $sformatf("%c", v[i*8 +: 8])};
    end
    return s;
  endfunction

  task automatic run_test();
    flit_t f;
    while (cmd_q.size() > 0) begin
      f = cmd_q.pop_front();
      @(negedge clk);
      debug_in_valid = 1'b1;
      debug_in_data  = f.data;
      debug_in_last  = f.last;
      do @(posedge clk); while (!debug_in_ready);
    end
    @(negedge clk);
    debug_in_valid = 1'b0;
    while (exp_req_addr.size() + exp_wdata.size() + exp_flit.size() + rd_q.size() != 0)
      @(negedge clk);
    repeat (20) @(negedge clk);   // Catch stray outputs
  endtask

  initial begin : main
    int          fd;
    int          code;
    int          nfields;
    logic [255:0] tagv;
    logic [255:0] namev;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    string       line;
    string       tag;
    fd = $fopen("verif/mam_golden.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the golden file verif/mam_golden.txt");
      $display("Test failed");
      $finish;
    end else begin
      while ($fscanf(fd, "%s", tagv) == 1) begin
        tag = text_of(tagv);
        if (tag == "#") begin
          code = $fgets(line, fd);   // Comment line
        end else begin
          a = '0;
          b = '0;
          c = '0;
          d = '0;
          namev = '0;
          if (tag == "Q") begin
            code    = $fscanf(fd, "%h %h %h %h", a, b, c, d);
            nfields = 4;
          end else if (tag == "E") begin
            code    = $fscanf(fd, "%s", namev);
            nfields = 1;
          end else if (tag == "C" || tag == "O" || tag == "W") begin
            code    = $fscanf(fd, "%h %h", a, b);
            nfields = 2;
          end else begin
            code    = $fscanf(fd, "%h", a);
            nfields = 1;
          end
          if (code != nfields) begin
            $display("Golden record with tag %s has missing or malformed fields", tag);
            file_errors++;
          end
          rec_tag.push_back(tag);
          rec_name.push_back(text_of(namev));
          rec_a.push_back(a);
          rec_b.push_back(b);
          rec_c.push_back(c);
          rec_d.push_back(d);
        end
      end
      $fclose(fd);
      limit = 40 * rec_tag.size() + 200;

      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      if (!debug_in_ready) begin
        $display("Test idle_after_reset: debug_in_ready is low after reset");
        test_errors++;
      end

      foreach (rec_tag[i]) begin
        case (rec_tag[i])
          "I": id = rec_a[i][15:0];
          "S": stall = rec_a[i][0];
          "C": cmd_q.push_back(flit_t'({rec_a[i][15:0], rec_b[i][0]}));
          "R": rd_q.push_back(word_t'(rec_a[i]));
          "Q": begin
            exp_req_we.push_back(rec_a[i][0]);
            exp_req_addr.push_back(addr_t'(rec_b[i]));
            exp_req_burst.push_back(rec_c[i][0]);
            exp_req_beats.push_back(beats_t'(rec_d[i]));
          end
          "W": begin
            exp_wdata.push_back(word_t'(rec_a[i]));
            exp_wstrb.push_back(strb_t'(rec_b[i]));
          end
          "O": exp_flit.push_back(flit_t'({rec_a[i][15:0], rec_b[i][0]}));
          "E": begin
            cur_name = rec_name[i];
            run_test();
            if (test_errors == 0) begin
              $display("Test %s: pass", cur_name);
              pass_count++;
            end else begin
              $display("Test %s: %0d errors", cur_name, test_errors);
              fail_count++;
            end
            test_errors = 0;
          end
          default: begin
            $display("Unknown golden record tag %s skipped", rec_tag[i]);
            file_errors++;
          end
        endcase
      end

      $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
      if (fail_count == 0 && file_errors == 0 && pass_count > 0) begin
        $display("Test completed successfully");
      end else begin
        $display("Test failed");
      end
      $finish;
    end
  end

endmodule

//--- all.f
+incdir+include
logic/mam_pkg.sv
logic/mam_fifo.sv
logic/mam_cmd_parser.sv
logic/mam_mem_sequencer.sv
logic/mam_resp_builder.sv
logic/mam_top.sv
verif/mam_sva.sv
verif/mam_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the memory access engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f all.f \
  --top-module mam_tb \
  -Mdir obj_dir

out=$(./obj_dir/Vmam_tb 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "Test completed successfully"; then
  exit 0
else
  exit 1
fi

//--- verif/mam_golden.txt
# Tags (hex fields): I id | S stall | C flit last | R read word | Q we addr burst beats
# W word strobe | O flit last | E test name
I 1234
E idle_after_reset
C 0001 0
C 0005 0
C 0000 0
C 8003 0
C 1000 0
C 0020 0
C dead 0
C beef 1
Q 1 10000020 0 1
W deadbeef 3
E single_write
C 0001 0
C 0006 0
C 0000 0
C c003 0
C 0000 0
C 0100 0
C 1111 0
C 2222 0
C 3333 0
C 4444 0
C 5555 0
C 6666 1
Q 1 00000100 1 3
W 11112222 f
W 33334444 f
W 55556666 f
E burst_write
C 0002 0
C 0007 0
C 0000 0
C 0000 0
C 0000 0
C 0040 1
R cafef00d
Q 0 00000040 0 1
O 0007 0
O 1234 0
O 8000 0
O cafe 0
O f00d 1
E short_read
S 1
C 0002 0
C 0009 0
C 0000 0
C 4004 0
C 0000 0
C 0200 1
C 0002 0
C 0009 0
C 0000 0
C 800f 0
C 0000 0
C 0300 0
C a5a5 0
C 5a5a 1
R 01020304
R 05060708
R 090a0b0c
R 0d0e0f10
Q 0 00000200 1 4
Q 1 00000300 0 1
W a5a55a5a f
O 0009 0
O 1234 0
O 8000 0
O 0102 0
O 0304 0
O 0506 0
O 0708 0
O 090a 1
O 0009 0
O 1234 0
O 8000 0
O 0b0c 0
O 0d0e 0
O 0f10 1
E long_read_stalled
S 0
